// ==== cs_decode_config.svh ====
// Chip-select decoder configuration

`ifndef CS_DECODE_CONFIG_SVH
`define CS_DECODE_CONFIG_SVH

// number of decoded 68000 regions and Z80 ports
`define CS_M68K_REGIONS 17
`define CS_Z80_PORTS    8

// input to select, in clock cycles
`define CS_LATENCY 2

// 68000 window bounds, inclusive
// region 0 (prog_rom) is the leftmost entry, region 16 (reset_z80) the rightmost
`define CS_M68K_LO_LIST { \
    24'h000000, 24'h080000, 24'h0c0000, \
    24'h100000, 24'h100002, 24'h100004, \
    24'h100006, 24'h100010, 24'h140000, \
    24'h140002, 24'h140008, 24'h144000, \
    24'h146000, 24'h180000, 24'h1c0000, \
    24'h1c0002, 24'h1c8000 }

`define CS_M68K_HI_LIST { \
    24'h07ffff, 24'h083fff, 24'h0c0fff, \
    24'h100001, 24'h100003, 24'h100005, \
    24'h100007, 24'h10001f, 24'h140001, \
    24'h140003, 24'h14000f, 24'h1447ff, \
    24'h1467ff, 24'h180fff, 24'h1c0001, \
    24'h1c0003, 24'h1c8001 }

// Z80 I/O port numbers
// p1, p2, system, dswa, dswb, sound0, sound1, tjump
`define CS_Z80_PORT_LIST { \
    8'h00, 8'h10, 8'h20, 8'h40, \
    8'h50, 8'h60, 8'h61, 8'h70 }

`endif

// ==== cs_decode_pkg.sv ====
// Chip-select decoder types

package cs_decode_pkg;

    // 68000 byte address and Z80 I/O port number
    typedef logic [23:0] m68k_addr_t;
    typedef logic [7:0]  z80_port_t;

    // one sampled 68000 bus cycle
    typedef struct packed {
        m68k_addr_t addr;
        logic       active;
    } m68k_bus_t;

    // one sampled Z80 I/O cycle
    typedef struct packed {
        z80_port_t addr;
        logic      active;
    } z80_bus_t;

    // 68000 region selects, in memory map order
    typedef struct packed {
        logic prog_rom;
        logic ram;
        logic sprite_ram;
        logic bcu_flip;
        logic tile_ofs;
        logic tile_attr;
        logic tile_num;
        logic scroll;
        logic vblank;
        logic int_en;
        logic crtc;
        logic tile_palette;
        logic sprite_palette;
        logic shared_ram;
        logic scroll_ofs_x;
        logic scroll_ofs_y;
        logic reset_z80;
    } m68k_sel_t;

    // Z80 port selects
    typedef struct packed {
        logic p1;
        logic p2;
        logic system;
        logic dswa;
        logic dswb;
        logic sound0;
        logic sound1;
        logic tjump;
    } z80_sel_t;

endpackage

// ==== bus_sampler.sv ====
// CPU bus sampler

`timescale 1ns/1ps

module bus_sampler
    import cs_decode_pkg::*;
#(
    parameter type addr_t = m68k_addr_t,
    parameter type bus_t  = m68k_bus_t
)
(
    input  logic  clk,
    input  logic  arst_n,

    // raw CPU side
    input  addr_t addr,
    input  logic  strobe_n,

    // qualified, registered cycle
    output bus_t  bus
);

    logic  active_d;
    addr_t addr_d;

    // strobes are active low on both CPUs
    assign active_d = ~strobe_n;

    // idle cycles carry a zero address
    always_comb
    begin
        if (active_d)
        begin
            addr_d = addr;
        end
        else
        begin
            addr_d = '0;
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            bus <= '0;
        end
        else
        begin
            bus.addr   <= addr_d;
            bus.active <= active_d;
        end
    end

endmodule

// ==== region_window.sv ====
// Address window compare

`timescale 1ns/1ps

module region_window
#(
    parameter type   addr_t = logic [7:0],
    parameter addr_t lo     = '0,
    parameter addr_t hi     = '0
)
(
    input  logic  valid,
    input  addr_t addr,
    output logic  hit
);

    logic above_lo;
    logic below_hi;

    // both bounds inclusive
    assign above_lo = (addr >= lo);
    assign below_hi = (addr <= hi);

    // a single port decodes as lo == hi
    assign hit = valid & above_lo & below_hi;

endmodule

// ==== select_collector.sv ====
// Select collector

`timescale 1ns/1ps

`include "cs_decode_config.svh"

module select_collector
    import cs_decode_pkg::*;
(
    input  logic                        clk,
    input  logic                        arst_n,

    // window results, bit i is region or port i
    input  logic [`CS_M68K_REGIONS-1:0] m68k_hit,
    input  logic                        m68k_active,
    input  logic [`CS_Z80_PORTS-1:0]    z80_hit,

    output m68k_sel_t                   m68k_sel,
    output z80_sel_t                    z80_sel,
    output logic                        unmapped
);

    m68k_sel_t m68k_sel_d;
    z80_sel_t  z80_sel_d;
    logic      unmapped_d;

    // hit index to named select
    always_comb
    begin
        m68k_sel_d.prog_rom       = m68k_hit[0];
        m68k_sel_d.ram            = m68k_hit[1];
        m68k_sel_d.sprite_ram     = m68k_hit[2];
        m68k_sel_d.bcu_flip       = m68k_hit[3];
        m68k_sel_d.tile_ofs       = m68k_hit[4];
        m68k_sel_d.tile_attr      = m68k_hit[5];
        m68k_sel_d.tile_num       = m68k_hit[6];
        m68k_sel_d.scroll         = m68k_hit[7];
        m68k_sel_d.vblank         = m68k_hit[8];
        m68k_sel_d.int_en         = m68k_hit[9];
        m68k_sel_d.crtc           = m68k_hit[10];
        m68k_sel_d.tile_palette   = m68k_hit[11];
        m68k_sel_d.sprite_palette = m68k_hit[12];
        m68k_sel_d.shared_ram     = m68k_hit[13];
        m68k_sel_d.scroll_ofs_x   = m68k_hit[14];
        m68k_sel_d.scroll_ofs_y   = m68k_hit[15];
        m68k_sel_d.reset_z80      = m68k_hit[16];
    end

    always_comb
    begin
        z80_sel_d.p1     = z80_hit[0];
        z80_sel_d.p2     = z80_hit[1];
        z80_sel_d.system = z80_hit[2];
        z80_sel_d.dswa   = z80_hit[3];
        z80_sel_d.dswb   = z80_hit[4];
        z80_sel_d.sound0 = z80_hit[5];
        z80_sel_d.sound1 = z80_hit[6];
        z80_sel_d.tjump  = z80_hit[7];
    end

    // strobed 68000 cycle that no window claims
    assign unmapped_d = m68k_active & ~(|m68k_hit);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            m68k_sel <= '0;
            z80_sel  <= '0;
            unmapped <= 1'b0;
        end
        else
        begin
            m68k_sel <= m68k_sel_d;
            z80_sel  <= z80_sel_d;
            unmapped <= unmapped_d;
        end
    end

endmodule

// ==== cs_decode_top.sv ====
// Chip-select decoder top

`timescale 1ns/1ps

`include "cs_decode_config.svh"

module cs_decode_top
    import cs_decode_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,

    // 68000 bus
    input  m68k_addr_t  cpu_a,
    input  logic        cpu_as_n,

    // Z80 bus, I/O cycles decode the low byte only
    input  logic [15:0] z80_addr,
    input  logic        iorq_n,

    output m68k_sel_t   m68k_sel,
    output z80_sel_t    z80_sel,
    output logic        unmapped
);

    localparam int m68k_aw = $bits(m68k_addr_t);
    localparam int z80_aw  = $bits(z80_port_t);

    localparam logic [`CS_M68K_REGIONS*m68k_aw-1:0] m68k_lo_list  = `CS_M68K_LO_LIST;
    localparam logic [`CS_M68K_REGIONS*m68k_aw-1:0] m68k_hi_list  = `CS_M68K_HI_LIST;
    localparam logic [`CS_Z80_PORTS*z80_aw-1:0]     z80_port_list = `CS_Z80_PORT_LIST;

    m68k_bus_t                   m68k_bus;
    z80_bus_t                    z80_bus;
    logic [`CS_M68K_REGIONS-1:0] m68k_hit;
    logic [`CS_Z80_PORTS-1:0]    z80_hit;

    bus_sampler #(
        .addr_t (m68k_addr_t),
        .bus_t  (m68k_bus_t)
    ) i_m68k_sampler (
        .clk      (clk),
        .arst_n   (arst_n),
        .addr     (cpu_a),
        .strobe_n (cpu_as_n),
        .bus      (m68k_bus)
    );

    bus_sampler #(
        .addr_t (z80_port_t),
        .bus_t  (z80_bus_t)
    ) i_z80_sampler (
        .clk      (clk),
        .arst_n   (arst_n),
        .addr     (z80_addr[7:0]),
        .strobe_n (iorq_n),
        .bus      (z80_bus)
    );

    // list entries run left to right from index 0
    for (genvar i = 0; i < `CS_M68K_REGIONS; i++)
    begin : g_m68k_window
        region_window #(
            .addr_t (m68k_addr_t),
            .lo     (m68k_lo_list[(`CS_M68K_REGIONS-1-i)*m68k_aw +: m68k_aw]),
            .hi     (m68k_hi_list[(`CS_M68K_REGIONS-1-i)*m68k_aw +: m68k_aw])
        ) i_window (
            .valid (m68k_bus.active),
            .addr  (m68k_bus.addr),
            .hit   (m68k_hit[i])
        );
    end

    for (genvar i = 0; i < `CS_Z80_PORTS; i++)
    begin : g_z80_window
        region_window #(
            .addr_t (z80_port_t),
            .lo     (z80_port_list[(`CS_Z80_PORTS-1-i)*z80_aw +: z80_aw]),
            .hi     (z80_port_list[(`CS_Z80_PORTS-1-i)*z80_aw +: z80_aw])
        ) i_window (
            .valid (z80_bus.active),
            .addr  (z80_bus.addr),
            .hit   (z80_hit[i])
        );
    end

    select_collector i_select_collector (
        .clk         (clk),
        .arst_n      (arst_n),
        .m68k_hit    (m68k_hit),
        .m68k_active (m68k_bus.active),
        .z80_hit     (z80_hit),
        .m68k_sel    (m68k_sel),
        .z80_sel     (z80_sel),
        .unmapped    (unmapped)
    );

endmodule

// ==== tb_cs_decode_model.svh ====
// Chip-select reference model

`ifndef TB_CS_DECODE_MODEL_SVH
`define TB_CS_DECODE_MODEL_SVH

localparam logic [`CS_M68K_REGIONS*24-1:0] model_lo_list   = `CS_M68K_LO_LIST;
localparam logic [`CS_M68K_REGIONS*24-1:0] model_hi_list   = `CS_M68K_HI_LIST;
localparam logic [`CS_Z80_PORTS*8-1:0]     model_port_list = `CS_Z80_PORT_LIST;

// list entry 0 sits in the top bits
function automatic m68k_addr_t window_lo(int idx);
    return model_lo_list[(`CS_M68K_REGIONS-1-idx)*24 +: 24];
endfunction

function automatic m68k_addr_t window_hi(int idx);
    return model_hi_list[(`CS_M68K_REGIONS-1-idx)*24 +: 24];
endfunction

function automatic z80_port_t port_number(int idx);
    return model_port_list[(`CS_Z80_PORTS-1-idx)*8 +: 8];
endfunction

// region i lands on struct bit REGIONS-1-i, prog_rom on top
function automatic logic [`CS_M68K_REGIONS-1:0] region_hits(m68k_addr_t a);
    logic [`CS_M68K_REGIONS-1:0] hits;
    hits = '0;
    for (int i = 0; i < `CS_M68K_REGIONS; i++)
    begin
        if (a >= window_lo(i) && a <= window_hi(i))
        begin
            hits[`CS_M68K_REGIONS-1-i] = 1'b1;
        end
    end
    return hits;
endfunction

function automatic m68k_sel_t expect_m68k_sel(m68k_addr_t a, logic as_n);
    return as_n ? '0 : m68k_sel_t'(region_hits(a));
endfunction

function automatic logic expect_unmapped(m68k_addr_t a, logic as_n);
    return !as_n && (region_hits(a) == '0);
endfunction

// only the low byte names the port
function automatic z80_sel_t expect_z80_sel(logic [15:0] za, logic io_n);
    logic [`CS_Z80_PORTS-1:0] sel;
    sel = '0;
    for (int i = 0; i < `CS_Z80_PORTS; i++)
    begin
        if (!io_n && za[7:0] == port_number(i))
        begin
            sel[`CS_Z80_PORTS-1-i] = 1'b1;
        end
    end
    return z80_sel_t'(sel);
endfunction

`endif

// ==== tb_cs_decode.sv ====
// Chip-select decoder testbench

`timescale 1ns/1ps

`include "cs_decode_config.svh"

module tb_cs_decode
    import cs_decode_pkg::*;
();

    localparam int clk_period     = 100;
    localparam int reset_cycles   = 5;
    localparam int idle_cycles    = 8;
    localparam int sweep_cycles   = 4 * `CS_M68K_REGIONS;
    localparam int random_cycles  = 3000;
    localparam int timeout_cycles = reset_cycles + idle_cycles + sweep_cycles
                                    + random_cycles + `CS_LATENCY + 20;

    logic        clk;
    logic        arst_n;
    m68k_addr_t  cpu_a;
    logic        cpu_as_n;
    logic [15:0] z80_addr;
    logic        iorq_n;
    m68k_sel_t   m68k_sel;
    z80_sel_t    z80_sel;
    logic        unmapped;

    integer      seed;
    int          error_count;
    int          check_count;

    // expected results in flight, oldest first
    m68k_sel_t   exp_m68k_q[$];
    z80_sel_t    exp_z80_q[$];
    logic        exp_unmapped_q[$];

    `include "tb_cs_decode_model.svh"

    cs_decode_top i_cs_decode_top (
        .clk      (clk),
        .arst_n   (arst_n),
        .cpu_a    (cpu_a),
        .cpu_as_n (cpu_as_n),
        .z80_addr (z80_addr),
        .iorq_n   (iorq_n),
        .m68k_sel (m68k_sel),
        .z80_sel  (z80_sel),
        .unmapped (unmapped)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial
    begin
        #(timeout_cycles * clk_period);
        $display("timeout: the run did not finish in %0d cycles", timeout_cycles);
        $display("Test failed");
        $finish;
    end

    task automatic compare_value(string name, logic [31:0] expected, logic [31:0] actual);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("error %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    // outputs settled since the last rising edge
    task automatic check_oldest();
        m68k_sel_t exp_m68k;
        z80_sel_t  exp_z80;
        logic      exp_unm;
        if (exp_m68k_q.size() == `CS_LATENCY)
        begin
            exp_m68k = exp_m68k_q.pop_front();
            exp_z80  = exp_z80_q.pop_front();
            exp_unm  = exp_unmapped_q.pop_front();
            compare_value("m68k_sel", {15'd0, exp_m68k}, {15'd0, m68k_sel});
            compare_value("z80_sel", {24'd0, exp_z80}, {24'd0, z80_sel});
            compare_value("unmapped", {31'd0, exp_unm}, {31'd0, unmapped});
        end
    endtask

    task automatic drive_cycle(m68k_addr_t a, logic as_n, logic [15:0] za, logic io_n);
        @(negedge clk);
        check_oldest();
        cpu_a    = a;
        cpu_as_n = as_n;
        z80_addr = za;
        iorq_n   = io_n;
        exp_m68k_q.push_back(expect_m68k_sel(a, as_n));
        exp_z80_q.push_back(expect_z80_sel(za, io_n));
        exp_unmapped_q.push_back(expect_unmapped(a, as_n));
    endtask

    // strobes off, addresses still moving
    task automatic idle_cycle();
        logic [31:0] rnd;
        rnd = $random(seed);
        drive_cycle(rnd[23:0], 1'b1, rnd[31:16], 1'b1);
    endtask

    // lo, hi and both neighbours of every window, back to back
    task automatic boundary_sweep();
        m68k_addr_t lo;
        m68k_addr_t hi;
        logic [7:0] port;
        for (int i = 0; i < `CS_M68K_REGIONS; i++)
        begin
            lo   = window_lo(i);
            hi   = window_hi(i);
            port = port_number(i % `CS_Z80_PORTS);
            drive_cycle(lo, 1'b0, {8'hc3, port}, 1'b0);
            drive_cycle(hi, 1'b0, {8'h3c, port}, 1'b0);
            drive_cycle(lo - 24'd1, 1'b0, {8'h5a, 8'hff}, 1'b0);
            drive_cycle(hi + 24'd1, 1'b0, {8'ha5, port}, 1'b1);
        end
    endtask

    task automatic random_cycle();
        logic [31:0] pick;
        logic [31:0] rnd_a;
        logic [31:0] rnd_b;
        logic [31:0] rnd_c;
        int          idx;
        m68k_addr_t  lo;
        m68k_addr_t  hi;
        m68k_addr_t  span;
        m68k_addr_t  a;
        logic        as_n;
        logic [15:0] za;
        logic        io_n;
        pick  = $random(seed);
        rnd_a = $random(seed);
        rnd_b = $random(seed);
        rnd_c = $random(seed);
        idx   = int'(rnd_a % `CS_M68K_REGIONS);
        lo    = window_lo(idx);
        hi    = window_hi(idx);
        span  = hi - lo + 24'd1;
        as_n  = 1'b0;
        case (pick[1:0])
            2'd0: a = lo + (rnd_b[23:0] % span);
            2'd1: a = rnd_b[0] ? lo - 24'd1 : hi + 24'd1;
            2'd2: a = rnd_b[23:0];
            default:
            begin
                a    = rnd_b[23:0];
                as_n = rnd_c[31];
            end
        endcase
        // upper z80 bits stay random in every case
        za   = rnd_c[15:0];
        io_n = 1'b0;
        case (pick[3:2])
            2'd0: za[7:0] = port_number(int'(rnd_c[18:16]));
            2'd1: io_n = 1'b0;
            default: io_n = rnd_c[20];
        endcase
        drive_cycle(a, as_n, za, io_n);
    endtask

    initial
    begin
        seed        = 29;
        error_count = 0;
        check_count = 0;
        arst_n      = 1'b0;
        cpu_a       = '0;
        cpu_as_n    = 1'b1;
        z80_addr    = '0;
        iorq_n      = 1'b1;
        repeat (reset_cycles) @(negedge clk);
        arst_n = 1'b1;
        // nothing strobed yet
        compare_value("m68k_sel", 32'd0, {15'd0, m68k_sel});
        compare_value("z80_sel", 32'd0, {24'd0, z80_sel});
        compare_value("unmapped", 32'd0, {31'd0, unmapped});
        repeat (idle_cycles) idle_cycle();
        boundary_sweep();
        repeat (random_cycles) random_cycle();
        repeat (`CS_LATENCY) drive_cycle('0, 1'b1, '0, 1'b1);
        $display("checks %0d errors %0d", check_count, error_count);
        if (error_count == 0)
        begin
            $display("Test completed successfully");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== cs_decode.f ====
+incdir+.
cs_decode_pkg.sv
bus_sampler.sv
region_window.sv
select_collector.sv
cs_decode_top.sv
tb_cs_decode.sv

// ==== Makefile ====
# Verilator build and run for the chip-select decoder

SIM = obj_dir/Vtb_cs_decode

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source, a header or the file list changes
$(SIM): cs_decode.f $(wildcard *.sv) $(wildcard *.svh)
	verilator --binary --timing -f cs_decode.f --top-module tb_cs_decode -o Vtb_cs_decode

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
